//--- id0_stage.f
source/isa_pkg.sv
source/core_pkg.sv
source/id0_comp_gpr.sv
source/id0_gpr.sv
source/regfile.sv
source/id0_stage.sv
sim/tb_clock.sv
sim/id0_stage_assert.sv
sim/id0_stage_tb.sv

//--- run.sh
#!/bin/sh
# builds the id0 stage testbench with Verilator, runs it and checks the log
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f id0_stage.f --top-module id0_stage_tb \
  -Mdir obj_dir -o id0_stage_sim
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/id0_stage_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "Test failed" sim.log; then
  exit 1
fi
exit 0

//--- sim/id0_stage_tb.sv
/* Testbench of the id0 decode stage
   random 32-bit and compressed instructions checked against a shadow register file */
module id0_stage_tb;
  import core_pkg::*;
  import isa_pkg::*;

  localparam int N_INSTR = 400;
  localparam int MAX_CYCLES = N_INSTR * 2 + 50;
  localparam logic [6:0] OPS [10] = '{OP, OP_IMM, LOAD, STORE, BRANCH, JAL, JALR, LUI, AUIPC,
                                      SYSTEM};
  // {funct3, quadrant} of every RV32C integer form plus the reserved 001_00
  localparam logic [4:0] C_FORMS [16] = '{5'b000_00, 5'b010_00, 5'b110_00, 5'b001_00,
                                          5'b000_01, 5'b001_01, 5'b010_01, 5'b011_01,
                                          5'b100_01, 5'b101_01, 5'b110_01, 5'b111_01,
                                          5'b000_10, 5'b010_10, 5'b100_10, 5'b110_10};

  logic            clk;
  logic            arst_n;
  logic            instr_valid;
  logic [31:0]     instr;
  wb_t             wb;
  id0_out_t        out;
  logic [15:0]     lfsr = 16'd36193;
  logic [XLEN-1:0] shadow [32];
  id0_out_t        exp_q [$];
  int              errors = 0;
  int              checks = 0;
  int              cycles = 0;
  bit              started = 1'b0;

  tb_clock #(.PERIOD(40)) clock_0 (.clk(clk));

  id0_stage #(.NUM_REGS(32)) DUT (
    .clk        (clk),
    .arst_n     (arst_n),
    .instr_valid(instr_valid),
    .instr      (instr),
    .wb         (wb),
    .out        (out)
  );

  // galois lfsr with taps 16 14 13 11 that steps once for every bit taken
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] r;
    r = '0;
    for (int b = 0; b < n; b++) begin
      r = {r[30:0], lfsr[0]};
      lfsr = lfsr[0] ? ((lfsr >> 1) ^ 16'hB400) : (lfsr >> 1);
    end
    return r;
  endfunction

  function automatic logic [31:0] new_instr(input bit comp);
    logic [31:0] i;
    logic [3:0]  sel;
    i = rand_bits(32);
    sel = 4'(rand_bits(4));
    if (!comp) begin
      if (sel > 4'd9) sel = sel - 4'd6;
      i[6:0] = OPS[sel];
    end else begin
      {i[15:13], i[1:0]} = C_FORMS[sel];  // upper half stays random and must be ignored
      if (C_FORMS[sel] == 5'b000_00) i[5] = 1'b1;  // keeps the addi4spn immediate nonzero
      if (C_FORMS[sel] == 5'b100_01) i[12] = 1'b0;
      if (rand_bits(1) != 0) begin
        if (C_FORMS[sel] == 5'b100_10) i[6:2] = X0;  // jr, jalr and ebreak
        if (C_FORMS[sel] == 5'b011_01) i[11:7] = X2;  // addi16sp
      end
    end
    return i;
  endfunction

  // expected register addresses from the RV32I and RV32C encodings
  function automatic reg_addrs_t ref_addrs(input logic [31:0] i);
    reg_addrs_t a;
    logic [4:0] p_hi;
    logic [4:0] p_lo;
    p_hi = {2'b01, i[9:7]};
    p_lo = {2'b01, i[4:2]};
    a = '{rd: i[11:7], rs1: X0, rs2: X0};
    if (i[1:0] == 2'b11) begin
      a.rs1 = i[19:15];
      a.rs2 = i[24:20];
      if (i[6:0] inside {STORE, BRANCH}) a.rd = X0;
      if (i[6:0] inside {LUI, AUIPC, JAL}) a.rs1 = X0;
      if (!(i[6:0] inside {OP, STORE, BRANCH, SYSTEM})) a.rs2 = X0;
    end else begin
      case ({i[15:13], i[1:0]})
        5'b000_00: {a.rd, a.rs1} = {p_lo, X2};
        5'b010_00: {a.rd, a.rs1} = {p_lo, p_hi};
        5'b110_00: {a.rd, a.rs1, a.rs2} = {X0, p_hi, p_lo};
        5'b000_01,
        5'b000_10: a.rs1 = i[11:7];  // addi, nop and slli read rd
        5'b001_01: a.rd = X1;
        5'b101_01: a.rd = X0;
        5'b110_01,
        5'b111_01: {a.rd, a.rs1} = {X0, p_hi};
        5'b011_01: a.rs1 = (i[11:7] == X2) ? X2 : X0;  // lui reads nothing
        5'b100_01: begin
          {a.rd, a.rs1} = {p_hi, p_hi};
          if (i[11:10] == 2'b11) a.rs2 = p_lo;
        end
        5'b010_10: a.rs1 = X2;
        5'b110_10: {a.rd, a.rs1, a.rs2} = {X0, X2, i[6:2]};
        5'b100_10: begin
          if (i[6:2] != X0) begin
            a.rs1 = i[12] ? i[11:7] : X0;  // add or mv
            a.rs2 = i[6:2];
          end else begin
            {a.rd, a.rs1} = {(i[12] && i[11:7] != X0) ? X1 : X0, i[11:7]};
          end
        end
        default: ;
      endcase
    end
    return a;
  endfunction

  function automatic logic [XLEN-1:0] ref_read(input reg_addr_t addr, input wb_t w);
    if (addr == X0) return '0;
    if (w.en && w.addr == addr) return w.data;
    return shadow[addr];
  endfunction

  task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("Fail %s: got 0x%0h, expected 0x%0h", name, got, exp);
    end
  endtask

  initial begin
    id0_out_t e;
    bit       comp;
    arst_n = 1'b0;
    instr_valid = 1'b0;
    instr = '0;
    wb = '0;
    for (int r = 0; r < 32; r++) shadow[r] = '0;
    repeat (2) @(posedge clk);
    @(negedge clk);
    arst_n = 1'b1;
    repeat (2) @(negedge clk);
    for (int n = 0; n < N_INSTR; n++) begin
      @(negedge clk);
      instr_valid = (rand_bits(2) != 0);
      comp = (rand_bits(1) != 0);
      instr = new_instr(comp);
      e.addrs = ref_addrs(instr);
      wb.en = (rand_bits(1) != 0);
      wb.addr = 5'(rand_bits(5));
      if (rand_bits(2) == 0) wb.addr = e.addrs.rs1;  // write and read in the same cycle
      wb.data = rand_bits(32);
      e.valid = instr_valid;
      e.compressed = comp;
      e.rs1_data = ref_read(e.addrs.rs1, wb);
      e.rs2_data = ref_read(e.addrs.rs2, wb);
      exp_q.push_back(e);
      if (wb.en && wb.addr != X0) shadow[wb.addr] = wb.data;
    end
    @(negedge clk);
    instr_valid = 1'b0;
    wb.en = 1'b0;
    while (exp_q.size() != 0) @(negedge clk);
    @(negedge clk);
    $display("%0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

  // samples out halfway between the capture edge and the next drive
  initial begin
    id0_out_t e;
    bit       due;
    forever begin
      @(posedge clk);
      #10;
      due = 1'b0;
      if (arst_n && exp_q.size() != 0) begin
        e = exp_q.pop_front();
        started = 1'b1;
        due = 1'b1;
      end else if (arst_n && !started) begin
        e = '0;  // nothing sent yet so every field reads zero
        due = 1'b1;
      end
      if (due) begin
        check("out.valid", 32'(out.valid), 32'(e.valid));
        if (e.valid || !started) begin
          check("out.compressed", 32'(out.compressed), 32'(e.compressed));
          check("out.addrs.rd", 32'(out.addrs.rd), 32'(e.addrs.rd));
          check("out.addrs.rs1", 32'(out.addrs.rs1), 32'(e.addrs.rs1));
          check("out.addrs.rs2", 32'(out.addrs.rs2), 32'(e.addrs.rs2));
          check("out.rs1_data", out.rs1_data, e.rs1_data);
          check("out.rs2_data", out.rs2_data, e.rs2_data);
        end
      end
    end
  end

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= MAX_CYCLES) begin
      $display("timeout after %0d cycles, the run did not reach its end", cycles);
      $display("Test failed");
      $finish;
    end
  end

endmodule

//--- sim/id0_stage_assert.sv
/* Output protocol checks of the id0 stage
   strobe latency, zero source data and reset behavior */
module id0_stage_assert (
  input logic               clk,
  input logic               arst_n,
  input logic               instr_valid,
  input core_pkg::id0_out_t out
);
  // a result leaves exactly one cycle after its strobe
  valid_rise: assert property (@(posedge clk) disable iff (!arst_n) instr_valid |=> out.valid)
    else $error("out.valid missing one cycle after instr_valid");

  valid_idle: assert property (@(posedge clk) disable iff (!arst_n) !instr_valid |=> !out.valid)
    else $error("out.valid set without an instruction one cycle before");

  zero_src: assert property (@(posedge clk) (out.addrs.rs1 == 5'd0) |-> (out.rs1_data == '0))
    else $error("out.rs1_data is not zero for source x0");

  reset_low: assert property (@(posedge clk) !arst_n |-> !out.valid)
    else $error("out.valid high during reset");
endmodule

bind id0_stage id0_stage_assert assert_0 (
  .clk        (clk),
  .arst_n     (arst_n),
  .instr_valid(instr_valid),
  .out        (out)
);

//--- sim/tb_clock.sv
/* Testbench clock source, free running from time zero */
module tb_clock #(
  parameter int PERIOD = 40
) (
  output logic clk
);
  initial begin
    clk = 1'b0;
    forever #(PERIOD / 2) clk = ~clk;
  end
endmodule

//--- source/id0_stage.sv
/* First decode stage of the RV32IC core
   detects compressed instructions, reads both operands and registers the result */
module id0_stage #(
  parameter int NUM_REGS = 32
) (
  input  logic               clk,
  input  logic               arst_n,
  input  logic               instr_valid,
  input  logic [31:0]        instr,
  input  core_pkg::wb_t      wb,
  output core_pkg::id0_out_t out
);
  import core_pkg::*;

  logic            compressed;
  reg_addrs_t      addrs;
  logic [XLEN-1:0] rs1_data;
  logic [XLEN-1:0] rs2_data;
  id0_out_t        out_d;

  // any low pair other than 2'b11 is a 16-bit instruction
  assign compressed = (instr[1:0] != 2'b11);

  id0_gpr gpr_0 (
    .instr     (instr),
    .compressed(compressed),
    .addrs     (addrs)
  );

  regfile #(
    .NUM_REGS(NUM_REGS)
  ) regfile_0 (
    .clk     (clk),
    .arst_n  (arst_n),
    .rs1_addr(addrs.rs1),
    .rs2_addr(addrs.rs2),
    .rs1_data(rs1_data),
    .rs2_data(rs2_data),
    .wb      (wb)
  );

  always_comb begin
    out_d       = out;  // fields hold between instructions
    out_d.valid = instr_valid;
    if (instr_valid) begin
      out_d.compressed = compressed;
      out_d.addrs      = addrs;
      out_d.rs1_data   = rs1_data;
      out_d.rs2_data   = rs2_data;
    end
  end

  // no back-pressure, the next stage takes every valid result
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      out <= '0;
    end else begin
      out <= out_d;
    end
  end

endmodule

//--- source/regfile.sv
/* Integer register file
   two combinational read ports, one write port, x0 reads zero, write-to-read bypass */
module regfile #(
  parameter int NUM_REGS = 32
) (
  input  logic                      clk,
  input  logic                      arst_n,
  input  core_pkg::reg_addr_t       rs1_addr,
  input  core_pkg::reg_addr_t       rs2_addr,
  output logic [core_pkg::XLEN-1:0] rs1_data,
  output logic [core_pkg::XLEN-1:0] rs2_data,
  input  core_pkg::wb_t             wb
);
  import core_pkg::*;

  logic [XLEN-1:0] regs [1:NUM_REGS-1];  // x0 has no storage
  reg_addr_t       rd_addr [2];
  logic [XLEN-1:0] rd_data [2];
  logic            wr_ok;

  assign wr_ok = wb.en && (wb.addr != '0) && (int'(wb.addr) < NUM_REGS);

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      for (int r = 1; r < NUM_REGS; r++) begin
        regs[r] <= '0;
      end
    end else if (wr_ok) begin
      regs[wb.addr] <= wb.data;
    end
  end

  assign rd_addr[0] = rs1_addr;
  assign rd_addr[1] = rs2_addr;

  always_comb begin
    for (int p = 0; p < 2; p++) begin
      if ((rd_addr[p] == '0) || (int'(rd_addr[p]) >= NUM_REGS)) begin
        rd_data[p] = '0;
      end else if (wr_ok && (wb.addr == rd_addr[p])) begin
        rd_data[p] = wb.data;  // same-cycle write wins over the stored word
      end else begin
        rd_data[p] = regs[rd_addr[p]];
      end
    end
  end

  assign rs1_data = rd_data[0];
  assign rs2_data = rd_data[1];

endmodule

//--- source/id0_gpr.sv
/* Register address decode
   chooses the compressed or 32-bit decode and zeroes fields the format leaves unused */
module id0_gpr (
  input  logic [31:0]          instr,
  input  logic                 compressed,
  output core_pkg::reg_addrs_t addrs
);
  import core_pkg::*;
  import isa_pkg::*;

  reg_addrs_t comp_addrs;
  reg_addrs_t full_addrs;
  op_e        opcode;

  id0_comp_gpr comp_gpr_0 (
    .en   (compressed),
    .instr(instr[15:0]),
    .addrs(comp_addrs)
  );

  assign opcode = op_e'(instr[6:0]);

  // unused fields go to x0 so they never look like real sources downstream
  always_comb begin
    full_addrs.rd  = instr[11:7];
    full_addrs.rs1 = instr[19:15];
    full_addrs.rs2 = instr[24:20];
    case (opcode)
      OP,
      SYSTEM: begin
        // all three fields as encoded
      end
      STORE,
      BRANCH: full_addrs.rd = X0;
      OP_IMM,
      LOAD,
      JALR: full_addrs.rs2 = X0;
      LUI,
      AUIPC,
      JAL: begin
        full_addrs.rs1 = X0;
        full_addrs.rs2 = X0;
      end
      default: begin
        // unknown opcode, raw fields are passed on
      end
    endcase
  end

  assign addrs = compressed ? comp_addrs : full_addrs;

endmodule

//--- source/id0_comp_gpr.sv
/* Compressed register decode
   classifies a 16-bit instruction and resolves its rd, rs1 and rs2 */
module id0_comp_gpr (
  input  logic                 en,
  input  logic [15:0]          instr,
  output core_pkg::reg_addrs_t addrs
);
  import core_pkg::*;
  import isa_pkg::*;

  c_op_e     c_op;
  logic [2:0] funct3;
  reg_addr_t rd_f;
  reg_addr_t rs2_f;
  reg_addr_t prime_hi;
  reg_addr_t prime_lo;

  assign funct3   = instr[15:13];
  assign rd_f     = instr[11:7];
  assign rs2_f    = instr[6:2];
  assign prime_hi = {2'b01, instr[9:7]};  // rs1' or rd' of the 3-bit forms, x8 to x15
  assign prime_lo = {2'b01, instr[4:2]};

  always_comb begin
    c_op = C_ILLEGAL;
    case (instr[1:0])
      Q0: begin
        case (funct3)
          3'b000:  c_op = (instr[12:5] != 8'd0) ? C_ADDI4SPN : C_ILLEGAL;  // zero imm is reserved
          3'b010:  c_op = C_LW;
          3'b110:  c_op = C_SW;
          default: c_op = C_ILLEGAL;
        endcase
      end
      Q1: begin
        case (funct3)
          3'b000: c_op = (rd_f == X0) ? C_NOP : C_ADDI;
          3'b001: c_op = C_JAL;
          3'b010: c_op = C_LI;
          3'b011: c_op = (rd_f == X2) ? C_ADDI16SP : C_LUI;
          3'b100: begin
            case (instr[11:10])
              2'b00: c_op = C_SRLI;
              2'b01: c_op = C_SRAI;
              2'b10: c_op = C_ANDI;
              default: begin
                case ({instr[12], instr[6:5]})  // bit 12 set is subw and addw, rv64 only
                  3'b000:  c_op = C_SUB;
                  3'b001:  c_op = C_XOR;
                  3'b010:  c_op = C_OR;
                  3'b011:  c_op = C_AND;
                  default: c_op = C_ILLEGAL;
                endcase
              end
            endcase
          end
          3'b101:  c_op = C_J;
          3'b110:  c_op = C_BEQZ;
          default: c_op = C_BNEZ;
        endcase
      end
      Q2: begin
        case (funct3)
          3'b000: c_op = C_SLLI;
          3'b010: c_op = C_LWSP;
          3'b100: begin
            if (!instr[12]) begin
              c_op = (rs2_f == X0) ? C_JR : C_MV;
            end else if (rs2_f != X0) begin
              c_op = C_ADD;
            end else begin
              c_op = (rd_f == X0) ? C_EBREAK : C_JALR;
            end
          end
          3'b110:  c_op = C_SWSP;
          default: c_op = C_ILLEGAL;
        endcase
      end
      default: c_op = C_ILLEGAL;
    endcase
  end

  always_comb begin
    addrs.rd  = rd_f;
    addrs.rs1 = X0;
    addrs.rs2 = X0;
    if (en) begin
      case (c_op)
        C_J:        addrs.rd = X0;
        C_JAL:      addrs.rd = X1;
        C_JR:       {addrs.rd, addrs.rs1} = {X0, rd_f};
        C_JALR:     {addrs.rd, addrs.rs1} = {X1, rd_f};
        C_BEQZ,
        C_BNEZ:     {addrs.rd, addrs.rs1, addrs.rs2} = {X0, prime_hi, X0};  // compare against x0
        C_ADDI4SPN: {addrs.rd, addrs.rs1} = {prime_lo, X2};
        C_LW:       {addrs.rd, addrs.rs1} = {prime_lo, prime_hi};
        C_SW:       {addrs.rd, addrs.rs1, addrs.rs2} = {X0, prime_hi, prime_lo};
        C_NOP:      addrs.rd = X0;
        C_ADDI,
        C_SLLI:     addrs.rs1 = rd_f;
        C_ADDI16SP: {addrs.rd, addrs.rs1} = {X2, X2};
        C_SRLI,
        C_SRAI,
        C_ANDI:     {addrs.rd, addrs.rs1} = {prime_hi, prime_hi};
        C_SUB,
        C_XOR,
        C_OR,
        C_AND:      {addrs.rd, addrs.rs1, addrs.rs2} = {prime_hi, prime_hi, prime_lo};
        C_LWSP:     addrs.rs1 = X2;
        C_SWSP:     {addrs.rd, addrs.rs1, addrs.rs2} = {X0, X2, rs2_f};
        C_MV:       addrs.rs2 = rs2_f;  // executes as add rd, x0, rs2
        C_ADD:      {addrs.rs1, addrs.rs2} = {rd_f, rs2_f};
        default: begin
          // li and lui only write rd, illegal and ebreak keep the raw field
        end
      endcase
    end
  end

endmodule

//--- source/core_pkg.sv
/* Pipeline types of the decode stage
   data width, register addresses, writeback request and stage result */
package core_pkg;

  localparam int XLEN = 32;  // fixed by the compressed encodings

  typedef logic [4:0] reg_addr_t;

  typedef struct packed {
    reg_addr_t rd;
    reg_addr_t rs1;
    reg_addr_t rs2;
  } reg_addrs_t;

  // write request from the writeback stage
  typedef struct packed {
    logic            en;
    reg_addr_t       addr;
    logic [XLEN-1:0] data;
  } wb_t;

  typedef struct packed {
    logic            valid;
    logic            compressed;
    reg_addrs_t      addrs;
    logic [XLEN-1:0] rs1_data;
    logic [XLEN-1:0] rs2_data;
  } id0_out_t;

endpackage

//--- source/isa_pkg.sv
/* RV32IC instruction encodings
   major opcodes, compressed instruction classes and the named registers */
package isa_pkg;

  // major opcodes of the 32-bit formats, bits 6:0
  typedef enum logic [6:0] {
    OP     = 7'b0110011,
    OP_IMM = 7'b0010011,
    LOAD   = 7'b0000011,
    STORE  = 7'b0100011,
    BRANCH = 7'b1100011,
    JAL    = 7'b1101111,
    JALR   = 7'b1100111,
    LUI    = 7'b0110111,
    AUIPC  = 7'b0010111,
    SYSTEM = 7'b1110011
  } op_e;

  // RV32C instruction classes, only what the register decode needs to tell apart
  typedef enum logic [4:0] {
    C_ILLEGAL,
    C_J, C_JAL, C_JR, C_JALR,
    C_BEQZ, C_BNEZ,
    C_ADDI4SPN, C_LW, C_SW,
    C_NOP, C_ADDI, C_LI, C_LUI, C_ADDI16SP,
    C_SRLI, C_SRAI, C_ANDI,
    C_SUB, C_XOR, C_OR, C_AND,
    C_SLLI, C_LWSP, C_SWSP,
    C_MV, C_ADD, C_EBREAK
  } c_op_e;

  // compressed quadrants, bits 1:0 (2'b11 is the 32-bit form)
  localparam logic [1:0] Q0 = 2'b00;
  localparam logic [1:0] Q1 = 2'b01;
  localparam logic [1:0] Q2 = 2'b10;

  localparam logic [4:0] X0 = 5'd0;  // zero
  localparam logic [4:0] X1 = 5'd1;  // ra, link register of c.jal and c.jalr
  localparam logic [4:0] X2 = 5'd2;  // sp

endpackage
